// ==== aes_ctrl_pkg.sv ====
// Operation, state and select encodings, round and bus constants, control word and status structs
package aes_ctrl_pkg;

	//==========================================================================
	// Widths and register map
	//==========================================================================
	// Round counter, wide enough for 14 rounds plus one
	localparam int ROUND_W = 4;
	localparam int APB_AW  = 4;

	// Word offsets on the APB side
	localparam logic [APB_AW-1:0] AES_CR = 4'd0;
	localparam logic [APB_AW-1:0] AES_SR = 4'd1;

	// Round count at the start of a pass
	localparam logic [ROUND_W-1:0] INITIAL_ROUND = '0;

	//==========================================================================
	// Operation and sequencer encodings
	//==========================================================================
	typedef enum logic [1:0] {
		ENCRYPTION     = 2'b00,
		KEY_DERIVATION = 2'b01,
		DECRYPTION     = 2'b10,
		DECRYP_W_DERIV = 2'b11
	} op_mode_e;

	// Column-serial sequencer, all 16 codes in use
	typedef enum logic [3:0] {
		IDLE        = 4'd0,
		ROUND0_COL0 = 4'd1,
		ROUND0_COL1 = 4'd2,
		ROUND0_COL2 = 4'd3,
		ROUND0_COL3 = 4'd4,
		ROUND_KEY0  = 4'd5,
		ROUND_COL0  = 4'd6,
		ROUND_COL1  = 4'd7,
		ROUND_COL2  = 4'd8,
		ROUND_COL3  = 4'd9,
		READY       = 4'd10,
		GEN_KEY0    = 4'd11,
		GEN_KEY1    = 4'd12,
		GEN_KEY2    = 4'd13,
		GEN_KEY3    = 4'd14,
		NOP         = 4'd15
	} seq_state_e;

	//==========================================================================
	// Datapath selects and enables
	//==========================================================================
	typedef enum logic [2:0] {
		COL_0      = 3'b000,
		COL_1      = 3'b001,
		COL_2      = 3'b010,
		COL_3      = 3'b011,
		G_FUNCTION = 3'b100
	} sbox_sel_e;

	typedef enum logic [1:0] {
		COL        = 2'b00,
		MIXCOL_IN  = 2'b01,
		MIXCOL_OUT = 2'b10
	} rk_sel_e;

	typedef enum logic [1:0] {
		SHIFT_ROWS = 2'b00,
		ADD_RK_OUT = 2'b01
	} col_sel_e;

	// Key word picked for the round-key adder
	localparam logic [1:0] KEY_0 = 2'b00;
	localparam logic [1:0] KEY_1 = 2'b01;
	localparam logic [1:0] KEY_2 = 2'b10;
	localparam logic [1:0] KEY_3 = 2'b11;

	// Key register load source
	localparam logic KEY_HOST = 1'b0;
	localparam logic KEY_OUT  = 1'b1;

	// One-hot word enables
	localparam logic [3:0] KEY_DIS  = 4'b0000;
	localparam logic [3:0] EN_KEY_0 = 4'b0001;
	localparam logic [3:0] EN_KEY_1 = 4'b0010;
	localparam logic [3:0] EN_KEY_2 = 4'b0100;
	localparam logic [3:0] EN_KEY_3 = 4'b1000;
	localparam logic [3:0] COL_DIS  = 4'b0000;
	localparam logic [3:0] EN_COL_0 = 4'b0001;
	localparam logic [3:0] EN_COL_1 = 4'b0010;
	localparam logic [3:0] EN_COL_2 = 4'b0100;
	localparam logic [3:0] EN_COL_3 = 4'b1000;
	localparam logic [3:0] COL_ALL  = 4'b1111;

	//==========================================================================
	// Structs
	//==========================================================================
	// Control word to the external datapath
	typedef struct packed {
		sbox_sel_e  sbox_sel;
		rk_sel_e    rk_sel;
		logic [1:0] key_out_sel;
		col_sel_e   col_sel;
		logic [3:0] key_en;
		logic [3:0] col_en;
		logic       bypass_rk;
		logic       bypass_key_en;
		logic       key_sel;
		logic       key_derivation_en;
	} aes_dp_ctrl_t;

	// Sequencer view shared with decoder and registers
	typedef struct packed {
		seq_state_e state;
		logic       enc_dec;
		logic       first_round;
		logic       last_round;
	} seq_status_t;

endpackage

// ==== aes_apb_regs.sv ====
// APB slave with control and status registers, start pulse and sticky done flag
`timescale 1ns/100ps
module aes_apb_regs
	import aes_ctrl_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	input  logic              end_comp,
	input  seq_status_t       status,
	output logic              start,
	output op_mode_e          op_mode,
	output logic              disable_core
);

	logic access;
	logic addr_ok;
	logic wr_cr;
	logic rd_sr;
	logic busy;
	logic done;

	//==========================================================================
	// Access decode
	//==========================================================================
	// Second phase of a transfer, zero wait states
	assign access  = psel & penable;
	assign addr_ok = (paddr == AES_CR) || (paddr == AES_SR);
	assign wr_cr   = access & pwrite & (paddr == AES_CR);
	assign rd_sr   = access & ~pwrite & (paddr == AES_SR);
	assign pready  = 1'b1;
	// Error only on unmapped offsets
	assign pslverr = access & ~addr_ok;

	// Busy whenever the sequencer has left IDLE
	assign busy = (status.state != IDLE);

	// Control register, bit 2 is not stored
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			op_mode      <= ENCRYPTION;
			disable_core <= 1'b0;
		end
		else if (wr_cr)
		begin
			op_mode      <= op_mode_e'(pwdata[1:0]);
			disable_core <= pwdata[3];
		end
	end

	// Start strobe, high the cycle after the access
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			start <= 1'b0;
		else
			start <= wr_cr & pwdata[2];
	end

	// Sticky done, a new completion wins over a status read
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			done <= 1'b0;
		else if (end_comp)
			done <= 1'b1;
		else if (rd_sr)
			done <= 1'b0;
	end

	// Read data
	always_comb
	begin
		prdata = '0;
		if (psel && !pwrite)
		begin
			case (paddr)
				AES_CR:  prdata = {28'd0, disable_core, 1'b0, op_mode};
				AES_SR:  prdata = {30'd0, busy, done};
				default: prdata = '0;
			endcase
		end
	end

endmodule

// ==== aes_round_seq.sv ====
// Round sequencer FSM, round counter and first/last round flags
`timescale 1ns/100ps
module aes_round_seq
	import aes_ctrl_pkg::*;
#(
	parameter int NUM_ROUNDS = 10
)
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  op_mode_e           op_mode,
	input  logic               disable_core,
	output seq_status_t        status,
	output logic [ROUND_W-1:0] round,
	output logic               end_comp
);

	// Final round, plus one for the decryption key pass
	localparam logic [ROUND_W-1:0] LAST_RD     = ROUND_W'(NUM_ROUNDS);
	localparam logic [ROUND_W-1:0] LAST_RD_INC = ROUND_W'(NUM_ROUNDS + 1);

	seq_state_e         state;
	seq_state_e         next_state;
	logic [ROUND_W-1:0] rd_count;
	logic               rd_count_en;
	logic               rd_count_clr;
	logic               enc_dec;
	logic               gen_key;
	logic               op_key_derivation;
	logic               first_round;
	logic               last_round;

	assign gen_key = (state == GEN_KEY0) || (state == GEN_KEY1) ||
		(state == GEN_KEY2) || (state == GEN_KEY3);
	// Forward direction, key expansion always runs forward
	assign enc_dec = (op_mode == ENCRYPTION) || (op_mode == KEY_DERIVATION) || gen_key;
	assign op_key_derivation = (op_mode == KEY_DERIVATION);

	// State register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else if (disable_core)
			state <= IDLE;
		else
			state <= next_state;
	end

	//==========================================================================
	// Next state
	//==========================================================================
	// Columns walk up when encrypting, down when decrypting
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				if (start)
				begin
					case (op_mode)
						ENCRYPTION: next_state = ROUND0_COL0;
						DECRYPTION: next_state = ROUND0_COL3;
						default:    next_state = GEN_KEY0;
					endcase
				end
			end
			ROUND0_COL0: next_state = enc_dec ? ROUND0_COL1 : ROUND_KEY0;
			ROUND0_COL1: next_state = enc_dec ? ROUND0_COL2 : ROUND0_COL0;
			ROUND0_COL2: next_state = enc_dec ? ROUND0_COL3 : ROUND0_COL1;
			ROUND0_COL3: next_state = enc_dec ? ROUND_KEY0 : ROUND0_COL2;
			ROUND_KEY0:
			begin
				if (first_round)
					next_state = enc_dec ? ROUND_COL0 : ROUND_COL3;
				else
					next_state = last_round ? READY : NOP;
			end
			// Spacer between rounds
			NOP:         next_state = enc_dec ? ROUND_COL0 : ROUND_COL3;
			ROUND_COL0:  next_state = enc_dec ? ROUND_COL1 : ROUND_KEY0;
			ROUND_COL1:  next_state = enc_dec ? ROUND_COL2 : ROUND_COL0;
			ROUND_COL2:  next_state = enc_dec ? ROUND_COL3 : ROUND_COL1;
			ROUND_COL3:
			begin
				if (enc_dec)
					next_state = last_round ? READY : ROUND_KEY0;
				else
					next_state = ROUND_COL2;
			end
			GEN_KEY0:    next_state = GEN_KEY1;
			GEN_KEY1:    next_state = GEN_KEY2;
			GEN_KEY2:    next_state = GEN_KEY3;
			GEN_KEY3:
			begin
				// Derivation alone ends here, else decrypt with the last key
				if (last_round)
					next_state = op_key_derivation ? READY : ROUND0_COL3;
				else
					next_state = GEN_KEY0;
			end
			READY:       next_state = IDLE;
		endcase
	end

	//==========================================================================
	// Round counter
	//==========================================================================
	// Holds at the final decryption key step so READY shows the round count
	assign rd_count_en = (state == GEN_KEY0) || ((state == ROUND_KEY0) && !last_round);
	// Restart before the decryption pass that follows expansion
	assign rd_count_clr = (state == IDLE) ||
		((state == GEN_KEY3) && last_round && !op_key_derivation);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_count <= INITIAL_ROUND;
		else if (rd_count_clr)
			rd_count <= INITIAL_ROUND;
		else if (rd_count_en)
			rd_count <= rd_count + 1'b1;
	end

	assign first_round = (rd_count == INITIAL_ROUND);
	assign last_round  = (rd_count == LAST_RD) || (rd_count == LAST_RD_INC);

	// Outputs
	assign round    = rd_count;
	assign end_comp = (state == READY);
	assign status   = '{state: state, enc_dec: enc_dec,
		first_round: first_round, last_round: last_round};

endmodule

// ==== aes_ctrl_decode.sv ====
// Per-state decode of the sequencer status into the datapath control word
`timescale 1ns/100ps
module aes_ctrl_decode
	import aes_ctrl_pkg::*;
(
	input  seq_status_t  status,
	input  op_mode_e     op_mode,
	output aes_dp_ctrl_t ctrl
);

	logic enc_dec;
	logic last_round;

	assign enc_dec    = status.enc_dec;
	assign last_round = status.last_round;

	always_comb
	begin
		// Idle datapath, nothing loads
		ctrl                   = '0;
		ctrl.sbox_sel          = COL_0;
		ctrl.rk_sel            = COL;
		ctrl.key_out_sel       = KEY_0;
		ctrl.col_sel           = SHIFT_ROWS;
		ctrl.key_sel           = KEY_HOST;
		ctrl.key_en            = KEY_DIS;
		ctrl.col_en            = COL_DIS;
		ctrl.bypass_rk         = 1'b0;
		ctrl.bypass_key_en     = 1'b0;
		ctrl.key_derivation_en = 1'b0;
		case (status.state)
			//==================================================================
			// Initial round, add round key only
			//==================================================================
			ROUND0_COL0:
			begin
				ctrl.bypass_rk     = 1'b1;
				ctrl.bypass_key_en = 1'b1;
				ctrl.col_sel       = enc_dec ? ADD_RK_OUT : SHIFT_ROWS;
				// Decrypt finishes with the inverse shift of all columns
				ctrl.col_en        = enc_dec ? EN_COL_0 : COL_ALL;
			end
			ROUND0_COL1, ROUND0_COL2:
			begin
				ctrl.sbox_sel      = (status.state == ROUND0_COL1) ? COL_1 : COL_2;
				ctrl.key_out_sel   = (status.state == ROUND0_COL1) ? KEY_1 : KEY_2;
				ctrl.bypass_rk     = 1'b1;
				ctrl.bypass_key_en = 1'b1;
				ctrl.col_sel       = ADD_RK_OUT;
				ctrl.col_en        = (status.state == ROUND0_COL1) ? EN_COL_1 : EN_COL_2;
				if (!enc_dec)
				begin
					ctrl.key_sel = KEY_OUT;
					ctrl.key_en  = (status.state == ROUND0_COL1) ? EN_KEY_1 : EN_KEY_2;
				end
			end
			ROUND0_COL3:
			begin
				ctrl.sbox_sel      = COL_3;
				ctrl.key_out_sel   = KEY_3;
				ctrl.bypass_rk     = 1'b1;
				ctrl.bypass_key_en = 1'b1;
				ctrl.col_sel       = enc_dec ? SHIFT_ROWS : ADD_RK_OUT;
				ctrl.col_en        = enc_dec ? COL_ALL : EN_COL_3;
				if (!enc_dec)
				begin
					ctrl.key_sel = KEY_OUT;
					ctrl.key_en  = EN_KEY_3;
				end
			end
			// Next key word 0 through the G function
			ROUND_KEY0:
			begin
				// Last decryption step already holds the cipher key
				if (!last_round)
				begin
					ctrl.sbox_sel = G_FUNCTION;
					ctrl.key_sel  = KEY_OUT;
					ctrl.key_en   = EN_KEY_0;
				end
			end
			//==================================================================
			// Cipher rounds, MixColumns skipped in the last one
			//==================================================================
			ROUND_COL0:
			begin
				ctrl.rk_sel  = last_round ? MIXCOL_IN : MIXCOL_OUT;
				ctrl.key_sel = KEY_OUT;
				if (enc_dec)
				begin
					ctrl.key_en  = EN_KEY_1;
					ctrl.col_sel = ADD_RK_OUT;
					ctrl.col_en  = EN_COL_0;
				end
				else
				begin
					ctrl.col_sel = last_round ? ADD_RK_OUT : SHIFT_ROWS;
					ctrl.col_en  = last_round ? EN_COL_0 : COL_ALL;
				end
			end
			ROUND_COL1, ROUND_COL2:
			begin
				ctrl.sbox_sel    = (status.state == ROUND_COL1) ? COL_1 : COL_2;
				ctrl.rk_sel      = last_round ? MIXCOL_IN : MIXCOL_OUT;
				ctrl.key_out_sel = (status.state == ROUND_COL1) ? KEY_1 : KEY_2;
				ctrl.key_sel     = KEY_OUT;
				ctrl.col_sel     = ADD_RK_OUT;
				ctrl.col_en      = (status.state == ROUND_COL1) ? EN_COL_1 : EN_COL_2;
				// Encrypt loads the word ahead, decrypt the same word
				if (status.state == ROUND_COL1)
					ctrl.key_en = enc_dec ? EN_KEY_2 : EN_KEY_1;
				else
					ctrl.key_en = enc_dec ? EN_KEY_3 : EN_KEY_2;
			end
			ROUND_COL3:
			begin
				ctrl.sbox_sel    = COL_3;
				ctrl.rk_sel      = last_round ? MIXCOL_IN : MIXCOL_OUT;
				ctrl.key_out_sel = KEY_3;
				ctrl.key_sel     = KEY_OUT;
				if (enc_dec)
				begin
					ctrl.col_sel = last_round ? ADD_RK_OUT : SHIFT_ROWS;
					ctrl.col_en  = last_round ? EN_COL_3 : COL_ALL;
				end
				else
				begin
					ctrl.key_en  = EN_KEY_3;
					ctrl.col_sel = ADD_RK_OUT;
					ctrl.col_en  = EN_COL_3;
				end
			end
			//==================================================================
			// Key expansion
			//==================================================================
			GEN_KEY0: ctrl.sbox_sel = G_FUNCTION;
			GEN_KEY1, GEN_KEY2, GEN_KEY3:
			begin
				ctrl.key_sel       = KEY_OUT;
				ctrl.bypass_key_en = 1'b1;
				case (status.state)
					// Words 0 and 1 together
					GEN_KEY1: ctrl.key_en = EN_KEY_0 | EN_KEY_1;
					GEN_KEY2: ctrl.key_en = EN_KEY_2;
					default:  ctrl.key_en = EN_KEY_3;
				endcase
			end
			// Derived key handed out only after derivation alone
			READY: ctrl.key_derivation_en = (op_mode == KEY_DERIVATION);
			default: ;
		endcase
	end

endmodule

// ==== aes_control_top.sv ====
// Top level of the AES controller, APB registers, round sequencer and control decode
`timescale 1ns/100ps
module aes_control_top
	import aes_ctrl_pkg::*;
#(
	parameter int NUM_ROUNDS = 10
)
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [APB_AW-1:0]  paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	output aes_dp_ctrl_t       ctrl,
	output logic [ROUND_W-1:0] round,
	output logic               end_comp
);

	logic        start;
	logic        disable_core;
	op_mode_e    op_mode;
	seq_status_t status;

	// Host registers
	aes_apb_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.end_comp(end_comp), .status(status),
		.start(start), .op_mode(op_mode), .disable_core(disable_core)
	);

	// Round sequencing
	aes_round_seq #(.NUM_ROUNDS(NUM_ROUNDS)) u_seq (
		.clk(clk), .rst_n(rst_n),
		.start(start), .op_mode(op_mode), .disable_core(disable_core),
		.status(status), .round(round), .end_comp(end_comp)
	);

	// Datapath control word
	aes_ctrl_decode u_dec (
		.status(status), .op_mode(op_mode), .ctrl(ctrl)
	);

endmodule

// ==== aes_control_chk.sv ====
// Concurrent assertions on sequencer timing, round count and key enables, with bind
`timescale 1ns/100ps
module aes_control_chk
	import aes_ctrl_pkg::*;
#(
	parameter int NUM_ROUNDS = 10
)
(
	input logic               clk,
	input logic               rst_n,
	input seq_status_t        status,
	input logic [ROUND_W-1:0] round,
	input logic               end_comp,
	input logic               disable_core,
	input aes_dp_ctrl_t       ctrl
);

	//==========================================================================
	// Sequencer properties
	//==========================================================================
	// READY lasts one cycle
	end_comp_single: assert property (@(posedge clk) disable iff (!rst_n)
		end_comp |=> !end_comp)
		else $error("end_comp stayed high for more than one cycle");

	// Round count shown in READY
	ready_round: assert property (@(posedge clk) disable iff (!rst_n)
		(status.state == READY) |-> (round == ROUND_W'(NUM_ROUNDS)))
		else $error("round count in READY differs from NUM_ROUNDS");

	// No key load while idle
	idle_key_en: assert property (@(posedge clk) disable iff (!rst_n)
		(status.state == IDLE) |-> (ctrl.key_en == '0))
		else $error("key_en active in IDLE");

	// Disable forces IDLE at the next edge
	disable_idle: assert property (@(posedge clk) disable iff (!rst_n)
		disable_core |=> (status.state == IDLE))
		else $error("sequencer not in IDLE one cycle after disable_core");

endmodule

bind aes_control_top aes_control_chk #(.NUM_ROUNDS(NUM_ROUNDS)) u_chk (
	.clk(clk), .rst_n(rst_n), .status(status), .round(round),
	.end_comp(end_comp), .disable_core(disable_core), .ctrl(ctrl)
);

// ==== tb_aes_control.sv ====
// Testbench for the AES controller with clock, reset, APB tasks, case loop, checks and timeout
`timescale 1ns/100ps
module tb_aes_control
	import aes_ctrl_pkg::*;
;

	localparam int          CLK_PERIOD = 20;
	localparam int          NUM_ROUNDS = 10;
	// Per-case allowance for gaps and register traffic
	localparam int          SLACK      = 50;
	// Cycles watched for a stray end_comp after disable
	localparam int          WATCH      = 80;
	localparam logic [31:0] SEED       = 32'ha2c9_2c8f;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [APB_AW-1:0]  paddr;
	logic [31:0]        pwdata;
	logic [31:0]        prdata;
	logic               pready;
	logic               pslverr;
	aes_dp_ctrl_t       ctrl;
	logic [ROUND_W-1:0] round;
	logic               end_comp;

	// Cases as read from the data file
	logic [1:0] case_op[$];
	int         case_lat[$];
	int         case_gfn[$];
	int         case_kd[$];

	int          errors;
	int          tests;
	int          cycles;
	int          limit;
	logic [31:0] lfsr;

	aes_control_top #(.NUM_ROUNDS(NUM_ROUNDS)) uut (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.ctrl(ctrl), .round(round), .end_comp(end_comp)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// Watchdog with a limit set once the cases are loaded
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	//==========================================================================
	// Helpers
	//==========================================================================
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One shift per bit taken
	task automatic random_bits(input int n, output int value);
		int i;
		value = 0;
		for (i = 0; i < n; i++)
		begin
			lfsr  = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic string op_name(input logic [1:0] op);
		case (op)
			2'd0:    return "encryption";
			2'd1:    return "key derivation";
			2'd2:    return "decryption";
			default: return "decryption with derivation";
		endcase
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected)
		begin
			$display("mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: FAILED", tests, name);
	endtask

	//==========================================================================
	// APB master
	//==========================================================================
	// Setup then access and return on the falling edge after the access
	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// Data and error taken mid access phase
	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
		output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD/4);
		data = prdata;
		err  = pslverr;
		// No wait states on this slave
		check_value(pready, 1'b1, "pready in access phase");
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Columns are op (hex), latency, G function cycles and key derivation flag
	task automatic load_cases();
		int    fd;
		int    got;
		int    op;
		int    lat;
		int    gfn;
		int    kd;
		int    total;
		string line;
		total = 0;
		fd = $fopen("aes_control_cases.txt", "r");
		if (fd == 0)
			$display("could not open the cases file aes_control_cases.txt");
		else
		begin
			while (!$feof(fd))
			begin
				got = $fgets(line, fd);
				if (got > 0 && line.len() > 0 && line[0] != "#")
				begin
					if ($sscanf(line, "%h %d %d %d", op, lat, gfn, kd) == 4)
					begin
						case_op.push_back(2'(op));
						case_lat.push_back(lat);
						case_gfn.push_back(gfn);
						case_kd.push_back(kd);
						total += lat;
					end
				end
			end
			$fclose(fd);
		end
		// Reset and disable tests counted as extra cases
		limit = total + SLACK * (case_op.size() + 3) + WATCH;
	endtask

	//==========================================================================
	// Tests
	//==========================================================================
	task automatic run_case(input int idx);
		int          gap;
		int          n;
		int          gfn;
		int          errs_before;
		logic [31:0] rdata;
		logic [31:0] busy_data;
		logic        err;
		logic [1:0]  op;
		errs_before = errors;
		op = case_op[idx];
		n = 0;
		gfn = 0;
		random_bits(3, gap);
		repeat (gap) @(negedge clk);
		apb_write(AES_CR, {28'd0, 1'b0, 1'b1, op});
		fork
			begin
				// Edges from the start sample until READY shows
				do
				begin
					@(posedge clk);
					n++;
					@(negedge clk);
					if (ctrl.sbox_sel == G_FUNCTION)
						gfn++;
				end
				while (!end_comp);
			end
			begin
				repeat (4) @(negedge clk);
				apb_read(AES_SR, busy_data, err);
				check_value(busy_data[1], 1, "busy during run");
			end
		join
		// Still in READY here
		check_value(n, case_lat[idx], "done latency");
		check_value(gfn, case_gfn[idx], "G function cycles");
		check_value(round, NUM_ROUNDS, "round in READY");
		check_value(ctrl.key_derivation_en, case_kd[idx], "key derivation enable");
		apb_read(AES_SR, rdata, err);
		check_value(rdata[1:0], 2'b01, "status after completion");
		apb_read(AES_SR, rdata, err);
		check_value(rdata[0], 0, "done after status read");
		report_test(op_name(op), errs_before);
	endtask

	// Watch for end_comp over a number of cycles
	task automatic watch_end_comp(input int n, inout int rises);
		repeat (n)
		begin
			@(negedge clk);
			if (end_comp)
				rises++;
		end
	endtask

	task automatic run_disable_test();
		int          rises;
		int          errs_before;
		logic [31:0] rdata;
		logic        err;
		errs_before = errors;
		rises = 0;
		apb_write(AES_CR, {28'd0, 1'b0, 1'b1, ENCRYPTION});
		watch_end_comp(10, rises);
		apb_read(AES_SR, rdata, err);
		check_value(rdata[1], 1, "busy before disable");
		apb_write(AES_CR, 32'h8);
		apb_read(AES_SR, rdata, err);
		check_value(rdata[1:0], 2'b00, "status after disable");
		watch_end_comp(WATCH, rises);
		check_value(rises, 0, "end_comp cycles in disabled run");
		apb_write(AES_CR, 32'h0);
		report_test("disable mid-run", errs_before);
	endtask

	task automatic run_unmapped_test();
		int          errs_before;
		logic [31:0] rdata;
		logic        err;
		errs_before = errors;
		apb_read(AES_CR, rdata, err);
		check_value(err, 0, "pslverr on AES_CR");
		apb_read(4'h5, rdata, err);
		check_value(err, 1, "pslverr on unmapped offset");
		check_value(rdata, 0, "read data from unmapped offset");
		report_test("unmapped access", errs_before);
	endtask

	initial
	begin
		int errs_before;
		int i;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		rst_n   = 1'b0;
		errors  = 0;
		tests   = 0;
		cycles  = 0;
		limit   = 0;
		lfsr    = SEED;
		load_cases();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Reset values
		errs_before = errors;
		check_value(end_comp, 0, "end_comp after reset");
		check_value(ctrl.key_en, 0, "key_en after reset");
		check_value(ctrl.col_en, 0, "col_en after reset");
		check_value(prdata, 0, "prdata after reset");
		if (case_op.size() == 0)
		begin
			$display("no test cases found in aes_control_cases.txt");
			errors++;
		end
		report_test("reset values", errs_before);

		for (i = 0; i < case_op.size(); i++)
			run_case(i);
		run_disable_test();
		run_unmapped_test();

		$display("tests run %0d, failed checks %0d", tests, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== aes_control_cases.txt ====
# op (hex) latency_cycles gfunction_cycles key_derivation_en
# op 0 encrypt, 1 key derivation, 2 decrypt, 3 decrypt with derivation
0 64 10 0
1 41 10 1
2 65 10 0
3 105 20 0
2 65 10 0
0 64 10 0
3 105 20 0
1 41 10 1

// ==== build.f ====
aes_ctrl_pkg.sv
aes_apb_regs.sv
aes_round_seq.sv
aes_ctrl_decode.sv
aes_control_top.sv
aes_control_chk.sv
tb_aes_control.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_aes_control

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_aes_control -f build.f

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
